// File: Bender.yml
package:
  name: edge_detect

sources:
  - rtl/edge_pkg.sv
  - rtl/edge_frame_ctrl.sv
  - rtl/edge_window.sv
  - rtl/edge_grad_x.sv
  - rtl/edge_grad_y.sv
  - rtl/edge_magnitude.sv
  - rtl/edge_detect_top.sv
  - target: test
    files:
      - bench/edge_clock_gen.sv
      - bench/edge_tb.sv

// File: bench/edge_clock_gen.sv
// ######################################################################
// testbench clock and reset: 10 ns clock, reset high for 16 cycles
// ######################################################################
`timescale 1ns/10ps

module edge_clock_gen (
    output logic clk_i,
    output logic rst_i
);

    initial begin
        clk_i = 1'b0;
        forever begin
            #5 clk_i = ~clk_i;
        end
    end

    // release reset on a falling edge, after 16 rising edges
    initial begin
        rst_i = 1'b1;
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
    end

endmodule

// File: bench/edge_tb.sv
// ######################################################################
// testbench for the edge engine: models both frame buffers, runs random
// and checkerboard frames and checks every write against a Sobel model
// ######################################################################
`timescale 1ns/10ps

module edge_tb;
    import edge_pkg::*;

    logic              clk_i;
    logic              rst_i;
    logic              start_i;
    logic [ADDR_W-1:0] rdaddr_o;
    logic [PIX_W-1:0]  rddata_i = '0;
    logic [ADDR_W-1:0] wraddr_o;
    logic [PIX_W-1:0]  wrdata_o;
    logic              we_o;
    logic              done_o;

    logic [PIX_W-1:0]  buf1 [NUM_PIX];
    logic [PIX_W-1:0]  buf2 [NUM_PIX];
    logic [PIX_W-1:0]  exp_pix [NUM_PIX];
    logic [ADDR_W-1:0] rd_addr_q = '0;
    int                wr_count;
    int                err_count = 0;
    int                cycle_count = 0;
    bit                last_seen = 1'b0;
    int                timeout_limit = 3 * (NUM_PIX + FLUSH_PIX + PIPE_LAT + 50) + 16;

    edge_clock_gen u_clk (
        .clk_i (clk_i),
        .rst_i (rst_i)
    );

    edge_detect_top u_dut (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .start_i  (start_i),
        .rdaddr_o (rdaddr_o),
        .rddata_i (rddata_i),
        .wraddr_o (wraddr_o),
        .wrdata_o (wrdata_o),
        .we_o     (we_o),
        .done_o   (done_o)
    );

    task automatic stop_run(input string reason);
        err_count++;
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic compare_addr(input string what, input logic [ADDR_W-1:0] got,
                                input logic [ADDR_W-1:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic compare_pixel(input string what, input logic [PIX_W-1:0] got,
                                 input logic [PIX_W-1:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    // reference: sum of absolute Sobel gradients on blue-nibble gray
    function automatic logic [PIX_W-1:0] model_pixel(input int r, input int c);
        int g [9];
        int gx;
        int gy;
        int mag;
        if (r == 0 || r == IMG_H - 1 || c == 0 || c == IMG_W - 1) begin
            return '0;
        end
        for (int i = 0; i < 9; i++) begin
            g[i] = (buf1[(r + i / 3 - 1) * IMG_W + c + i % 3 - 1] & 15) * 16;
        end
        gx = (g[2] + 2 * g[5] + g[8]) - (g[0] + 2 * g[3] + g[6]);
        gy = (g[6] + 2 * g[7] + g[8]) - (g[0] + 2 * g[1] + g[2]);
        mag = (gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy);
        if (mag > 255) begin
            mag = 255;
        end
        return PIX_W'((mag / 16) * 'h111);
    endfunction

    task automatic fill_random();
        for (int i = 0; i < NUM_PIX; i++) begin
            buf1[i] = PIX_W'($urandom);
        end
    endtask

    // 2x2 cells of full and empty blue, random red and green on top
    task automatic fill_checker();
        logic [7:0] upper;
        for (int i = 0; i < NUM_PIX; i++) begin
            upper = 8'($urandom);
            buf1[i] = {upper, ((((i / IMG_W) >> 1) + ((i % IMG_W) >> 1)) & 1) ? 4'hf : 4'h0};
        end
    endtask

    task automatic run_frame(input bit poke_mid);
        for (int i = 0; i < NUM_PIX; i++) begin
            exp_pix[i] = model_pixel(i / IMG_W, i % IMG_W);
        end
        wr_count = 0;
        start_i = 1'b1;
        @(negedge clk_i);
        start_i = 1'b0;
        if (poke_mid) begin
            while (wr_count < 100) @(negedge clk_i);
            start_i = 1'b1;
            @(negedge clk_i);
            start_i = 1'b0;
        end
        while (!done_o) @(negedge clk_i);
        compare_addr("write count", ADDR_W'(wr_count), ADDR_W'(NUM_PIX));
        repeat (10) begin
            @(negedge clk_i);
            if (!done_o) stop_run("done_o dropped without a new start");
        end
    endtask

    // buffer 1 read port, data lands one clock after its address
    always @(negedge clk_i) begin
        rddata_i = buf1[rd_addr_q];
        rd_addr_q = rdaddr_o;
    end

    // buffer 2 write port and strobe checks
    always @(negedge clk_i) begin
        if (!rst_i) begin
            if (last_seen && !done_o) stop_run("done_o did not rise after the last write");
            if (we_o) begin
                if (done_o) stop_run("write strobe while done_o is high");
                compare_addr("write address", wraddr_o, ADDR_W'(wr_count));
                compare_pixel($sformatf("pixel %0d", wraddr_o), wrdata_o, exp_pix[wraddr_o]);
                buf2[wraddr_o] = wrdata_o;
                wr_count++;
            end
            last_seen = we_o && (wraddr_o == ADDR_W'(NUM_PIX - 1));
        end
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= timeout_limit) stop_run("run did not finish in time");
    end

    initial begin
        void'($urandom(96050));
        start_i = 1'b0;
        wr_count = 0;
        wait (rst_i == 1'b0);
        repeat (20) begin
            @(negedge clk_i);
            if (we_o || done_o) stop_run("we_o or done_o went high before any start");
            compare_addr("idle read address", rdaddr_o, '0);
        end
        fill_random();
        run_frame(1'b1);
        fill_checker();
        run_frame(1'b0);
        fill_random();
        run_frame(1'b0);
        if (err_count == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            stop_run("checks reported errors");
        end
    end

endmodule

// File: compile.f
rtl/edge_pkg.sv
rtl/edge_frame_ctrl.sv
rtl/edge_window.sv
rtl/edge_grad_x.sv
rtl/edge_grad_y.sv
rtl/edge_magnitude.sv
rtl/edge_detect_top.sv
bench/edge_clock_gen.sv
bench/edge_tb.sv

// File: rtl/edge_detect_top.sv
// ######################################################################
// edge engine top: frame controller, window, both gradient units and
// the magnitude stage between a read and a write frame buffer
// ######################################################################
`timescale 1ns/10ps

module edge_detect_top (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        start_i,
    output logic [edge_pkg::ADDR_W-1:0] rdaddr_o,
    input  logic [edge_pkg::PIX_W-1:0]  rddata_i,
    output logic [edge_pkg::ADDR_W-1:0] wraddr_o,
    output logic [edge_pkg::PIX_W-1:0]  wrdata_o,
    output logic                        we_o,
    output logic                        done_o
);
    import edge_pkg::*;

    logic              shift_en;
    logic              flush;
    logic              border;
    logic [GRAY_W-1:0] win_00, win_01, win_02;
    logic [GRAY_W-1:0] win_10, win_12;
    logic [GRAY_W-1:0] win_20, win_21, win_22;
    logic [GRAD_W-1:0] gx_abs;
    logic [GRAD_W-1:0] gy_abs;

    edge_frame_ctrl u_ctrl (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .start_i  (start_i),
        .rdaddr_o (rdaddr_o),
        .shift_en (shift_en),
        .flush    (flush),
        .border   (border),
        .wraddr_o (wraddr_o),
        .we_o     (we_o),
        .done_o   (done_o)
    );

    // center tap has zero weight in both Sobel kernels
    edge_window u_window (
        .clk_i    (clk_i),
        .rddata_i (rddata_i),
        .shift_en (shift_en),
        .flush    (flush),
        .win_00   (win_00),
        .win_01   (win_01),
        .win_02   (win_02),
        .win_10   (win_10),
        .win_11   (),
        .win_12   (win_12),
        .win_20   (win_20),
        .win_21   (win_21),
        .win_22   (win_22)
    );

    // both gradients work on the same window in parallel
    edge_grad_x u_grad_x (
        .clk_i  (clk_i),
        .win_00 (win_00),
        .win_10 (win_10),
        .win_20 (win_20),
        .win_02 (win_02),
        .win_12 (win_12),
        .win_22 (win_22),
        .gx_abs (gx_abs)
    );

    edge_grad_y u_grad_y (
        .clk_i  (clk_i),
        .win_00 (win_00),
        .win_01 (win_01),
        .win_02 (win_02),
        .win_20 (win_20),
        .win_21 (win_21),
        .win_22 (win_22),
        .gy_abs (gy_abs)
    );

    edge_magnitude u_mag (
        .clk_i    (clk_i),
        .gx_abs   (gx_abs),
        .gy_abs   (gy_abs),
        .border   (border),
        .wrdata_o (wrdata_o)
    );

endmodule

// File: rtl/edge_frame_ctrl.sv
// ######################################################################
// frame sequencer: issues one read slot per clock, tracks output position
// and delays write strobe, address and border flag to meet the datapath
// ######################################################################
`timescale 1ns/10ps

module edge_frame_ctrl (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        start_i,
    output logic [edge_pkg::ADDR_W-1:0] rdaddr_o,
    output logic                        shift_en,
    output logic                        flush,
    output logic                        border,
    output logic [edge_pkg::ADDR_W-1:0] wraddr_o,
    output logic                        we_o,
    output logic                        done_o
);
    import edge_pkg::*;

    logic [1:0]               state;
    logic [ADDR_W-1:0]        rd_slot;
    logic                     slot_valid;
    logic                     out_slot;
    logic                     out_border;
    logic [ADDR_W-1:0]        out_addr;
    logic [COL_W-1:0]         out_col;
    logic [$clog2(IMG_H)-1:0] out_row;
    logic                     last_write;

    // delay line toward the write port
    logic [PIPE_LAT-1:0]      we_dly;
    logic [ADDR_W-1:0]        addr_dly [PIPE_LAT];
    logic [PIPE_LAT-2:0]      border_dly;

    // a frame is every pixel plus the flush slots
    assign slot_valid = (state == ST_RUN) && (rd_slot < ADDR_W'(NUM_PIX + FLUSH_PIX));

    // window center lags the newest sample by one row and one pixel
    assign out_slot = slot_valid && (rd_slot >= ADDR_W'(IMG_W + 1));
    assign out_addr = rd_slot - ADDR_W'(IMG_W + 1);

    assign out_border = (out_row == '0) ||
                        (out_row == $bits(out_row)'(IMG_H - 1)) ||
                        (out_col == '0) ||
                        (out_col == COL_W'(IMG_W - 1));

    // flush slots keep the last valid address on the bus
    assign rdaddr_o = (rd_slot < ADDR_W'(NUM_PIX)) ? rd_slot : ADDR_W'(NUM_PIX - 1);

    assign last_write = we_o && (wraddr_o == ADDR_W'(NUM_PIX - 1));
    assign done_o     = (state == ST_DONE);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state   <= ST_IDLE;
            rd_slot <= '0;
            out_col <= '0;
            out_row <= '0;
        end else begin
            case (state)
                ST_IDLE, ST_DONE: begin
                    if (start_i) begin
                        state   <= ST_RUN;
                        rd_slot <= '0;
                        out_col <= '0;
                        out_row <= '0;
                    end
                end
                ST_RUN: begin
                    // start is ignored here, the frame runs to the end
                    if (slot_valid) begin
                        rd_slot <= rd_slot + 1'b1;
                    end
                    if (out_slot) begin
                        if (out_col == COL_W'(IMG_W - 1)) begin
                            out_col <= '0;
                            out_row <= out_row + 1'b1;
                        end else begin
                            out_col <= out_col + 1'b1;
                        end
                    end
                    if (last_write) begin
                        state <= ST_DONE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // strobes and window controls
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            we_dly   <= '0;
            shift_en <= 1'b0;
            flush    <= 1'b0;
        end else begin
            we_dly   <= {we_dly[PIPE_LAT-2:0], out_slot};
            // read data shows up one clock after its address
            shift_en <= slot_valid;
            flush    <= slot_valid && (rd_slot >= ADDR_W'(NUM_PIX));
        end
    end

    always_ff @(posedge clk_i) begin
        addr_dly[0] <= out_addr;
        for (int i = 1; i < PIPE_LAT; i++) begin
            addr_dly[i] <= addr_dly[i-1];
        end
        border_dly <= {border_dly[PIPE_LAT-3:0], out_border};
    end

    assign we_o     = we_dly[PIPE_LAT-1];
    assign wraddr_o = addr_dly[PIPE_LAT-1];
    // magnitude stage registers one clock before the strobe
    assign border   = border_dly[PIPE_LAT-2];

    // delayed address must stay inside buffer 2
    a_wraddr_range : assert property (
        @(posedge clk_i) disable iff (rst_i)
        we_o |-> (wraddr_o < ADDR_W'(NUM_PIX))
    ) else $error("write strobe with address %0d outside the frame", wraddr_o);

endmodule

// File: rtl/edge_grad_x.sv
// ######################################################################
// horizontal Sobel gradient, right column minus left column, absolute
// value registered once
// ######################################################################
`timescale 1ns/10ps

module edge_grad_x (
    input  logic                        clk_i,
    input  logic [edge_pkg::GRAY_W-1:0] win_00,
    input  logic [edge_pkg::GRAY_W-1:0] win_10,
    input  logic [edge_pkg::GRAY_W-1:0] win_20,
    input  logic [edge_pkg::GRAY_W-1:0] win_02,
    input  logic [edge_pkg::GRAY_W-1:0] win_12,
    input  logic [edge_pkg::GRAY_W-1:0] win_22,
    output logic [edge_pkg::GRAD_W-1:0] gx_abs
);
    import edge_pkg::*;

    logic [GRAD_W-1:0] sum_l;
    logic [GRAD_W-1:0] sum_r;

    // weights 1 2 1 down each column
    assign sum_l = GRAD_W'(win_00) + GRAD_W'({win_10, 1'b0}) + GRAD_W'(win_20);
    assign sum_r = GRAD_W'(win_02) + GRAD_W'({win_12, 1'b0}) + GRAD_W'(win_22);

    always_ff @(posedge clk_i) begin
        gx_abs <= (sum_r >= sum_l) ? (sum_r - sum_l) : (sum_l - sum_r);
    end

    a_gx_bound : assert property (
        @(posedge clk_i)
        !$isunknown(gx_abs) |-> (gx_abs <= GRAD_W'(4 * ((1 << GRAY_W) - 1)))
    ) else $error("horizontal gradient %0d above 1020", gx_abs);

endmodule

// File: rtl/edge_grad_y.sv
// ######################################################################
// vertical Sobel gradient, bottom row minus top row, absolute value
// registered once
// ######################################################################
`timescale 1ns/10ps

module edge_grad_y (
    input  logic                        clk_i,
    input  logic [edge_pkg::GRAY_W-1:0] win_00,
    input  logic [edge_pkg::GRAY_W-1:0] win_01,
    input  logic [edge_pkg::GRAY_W-1:0] win_02,
    input  logic [edge_pkg::GRAY_W-1:0] win_20,
    input  logic [edge_pkg::GRAY_W-1:0] win_21,
    input  logic [edge_pkg::GRAY_W-1:0] win_22,
    output logic [edge_pkg::GRAD_W-1:0] gy_abs
);
    import edge_pkg::*;

    logic [GRAD_W-1:0] sum_t;
    logic [GRAD_W-1:0] sum_b;

    // weights 1 2 1 along each row
    assign sum_t = GRAD_W'(win_00) + GRAD_W'({win_01, 1'b0}) + GRAD_W'(win_02);
    assign sum_b = GRAD_W'(win_20) + GRAD_W'({win_21, 1'b0}) + GRAD_W'(win_22);

    always_ff @(posedge clk_i) begin
        gy_abs <= (sum_b >= sum_t) ? (sum_b - sum_t) : (sum_t - sum_b);
    end

    a_gy_bound : assert property (
        @(posedge clk_i)
        !$isunknown(gy_abs) |-> (gy_abs <= GRAD_W'(4 * ((1 << GRAY_W) - 1)))
    ) else $error("vertical gradient %0d above 1020", gy_abs);

endmodule

// File: rtl/edge_magnitude.sv
// ######################################################################
// gradient magnitude as |gx| + |gy| saturated to 8 bits, zero on the
// frame border, widened to an RGB444 pixel for buffer 2
// ######################################################################
`timescale 1ns/10ps

module edge_magnitude (
    input  logic                        clk_i,
    input  logic [edge_pkg::GRAD_W-1:0] gx_abs,
    input  logic [edge_pkg::GRAD_W-1:0] gy_abs,
    input  logic                        border,
    output logic [edge_pkg::PIX_W-1:0]  wrdata_o
);
    import edge_pkg::*;

    logic [GRAD_W:0]   sum;
    logic [GRAY_W-1:0] mag;

    // one extra bit so the sum cannot wrap
    assign sum = {1'b0, gx_abs} + {1'b0, gy_abs};

    always_comb begin
        if (border) begin
            mag = '0;
        end else if (sum > (GRAD_W + 1)'((1 << GRAY_W) - 1)) begin
            mag = '1;
        end else begin
            mag = sum[GRAY_W-1:0];
        end
    end

    // upper nibble copied into R, G and B
    always_ff @(posedge clk_i) begin
        wrdata_o <= {3{mag[GRAY_W-1 -: 4]}};
    end

endmodule

// File: rtl/edge_pkg.sv
// ######################################################################
// shared geometry, widths and pipeline timing for the edge engine
// imported by every RTL block and by the testbench
// ######################################################################

package edge_pkg;

    // frame geometry
    localparam int IMG_W   = 32;
    localparam int IMG_H   = 24;
    localparam int NUM_PIX = IMG_W * IMG_H;

    // data and address widths
    localparam int ADDR_W = 10;
    localparam int PIX_W  = 12;
    localparam int GRAY_W = 8;
    // absolute gradient, 4 * 255 = 1020 at most
    localparam int GRAD_W = 10;
    localparam int COL_W  = 5;

    // read address to write strobe, in clocks
    localparam int PIPE_LAT = 4;
    // extra read slots that push the last window centers out
    localparam int FLUSH_PIX = IMG_W + 1;

    // controller FSM encoding
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_RUN  = 2'd1;
    localparam logic [1:0] ST_DONE = 2'd2;

endpackage

// File: rtl/edge_window.sv
// ######################################################################
// gray conversion, two line buffers and the 3x3 window around a center
// that lags the newest sample by one row and one pixel
// ######################################################################
`timescale 1ns/10ps

module edge_window (
    input  logic                        clk_i,
    input  logic [edge_pkg::PIX_W-1:0]  rddata_i,
    input  logic                        shift_en,
    input  logic                        flush,
    output logic [edge_pkg::GRAY_W-1:0] win_00,
    output logic [edge_pkg::GRAY_W-1:0] win_01,
    output logic [edge_pkg::GRAY_W-1:0] win_02,
    output logic [edge_pkg::GRAY_W-1:0] win_10,
    output logic [edge_pkg::GRAY_W-1:0] win_11,
    output logic [edge_pkg::GRAY_W-1:0] win_12,
    output logic [edge_pkg::GRAY_W-1:0] win_20,
    output logic [edge_pkg::GRAY_W-1:0] win_21,
    output logic [edge_pkg::GRAY_W-1:0] win_22
);
    import edge_pkg::*;

    logic [GRAY_W-1:0] gray;
    logic [GRAY_W-1:0] line1 [IMG_W];
    logic [GRAY_W-1:0] line2 [IMG_W];

    // blue nibble moved to the top, flush slots enter as black
    assign gray = flush ? '0 : {rddata_i[3:0], {(GRAY_W - 4){1'b0}}};

    always_ff @(posedge clk_i) begin
        if (shift_en) begin
            // line1 holds the last IMG_W samples, line2 the row before
            line1[0] <= gray;
            line2[0] <= line1[IMG_W-1];
            for (int i = 1; i < IMG_W; i++) begin
                line1[i] <= line1[i-1];
                line2[i] <= line2[i-1];
            end

            // bottom row is the newest data
            win_22 <= gray;
            win_21 <= win_22;
            win_20 <= win_21;

            win_12 <= line1[IMG_W-1];
            win_11 <= win_12;
            win_10 <= win_11;

            win_02 <= line2[IMG_W-1];
            win_01 <= win_02;
            win_00 <= win_01;
        end
    end

endmodule
